/* logic/lsq_pkg.sv */
// Load/store unit shared definitions
// sizes, width types and the FSM state encodings
package lsq_pkg;

	// ******************************************************************
	// sizes
	// ******************************************************************
	localparam int SQ_ENTRIES = 8;
	localparam int SQ_IDX_W   = 3;
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 64;

	// ******************************************************************
	// types
	// ******************************************************************
	typedef logic [SQ_IDX_W-1:0] sq_idx_t;
	// slot index plus wrap bit in the msb
	typedef logic [SQ_IDX_W:0]   sq_ptr_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;

	typedef enum logic [1:0] {
		DR_IDLE,
		DR_REQ,
		DR_RELEASE
	} drain_state_e;

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_WAIT_OLDER,
		LD_MEM_REQ,
		LD_MEM_RELEASE,
		LD_ACK
	} ld_state_e;

endpackage

/* logic/lsq_ifs.sv */
// Store queue interfaces
// slot control pulses from the allocator, and the per-slot view of the queue

interface sq_ctrl_if;
	import lsq_pkg::*;

	// one-cycle pulses, a slot acts when the index is its own
	logic    alloc_en;
	sq_idx_t alloc_idx;
	logic    commit_en;
	sq_idx_t commit_idx;
	logic    free_en;
	sq_idx_t free_idx;

	modport alloc (
		output alloc_en, alloc_idx,
		output commit_en, commit_idx,
		output free_en, free_idx
	);

	modport slot (
		input alloc_en, alloc_idx,
		input commit_en, commit_idx,
		input free_en, free_idx
	);
endinterface

interface sq_view_if;
	import lsq_pkg::*;

	// each slot drives its own element
	logic  valid     [SQ_ENTRIES];
	logic  addr_vld  [SQ_ENTRIES];
	logic  committed [SQ_ENTRIES];
	logic  match     [SQ_ENTRIES];
	addr_t addr      [SQ_ENTRIES];
	data_t data      [SQ_ENTRIES];
	// address of the load in flight
	addr_t search_addr;

	modport slot (output valid, addr_vld, committed, match, addr, data, input search_addr);
	modport search (input valid, addr_vld, match, data);
	modport drain (input committed, addr, data);
	modport load (output search_addr);
endinterface

/* logic/sq_alloc.sv */
// Store queue allocator
// head, commit and tail pointers; issues allocate, commit and free pulses
module sq_alloc (
	input  logic             clk,
	input  logic             rst,
	input  logic             disp_i,
	input  logic             commit_i,
	input  logic             drain_done_i,
	output logic             disp_ready_o,
	output lsq_pkg::sq_idx_t disp_idx_o,
	output lsq_pkg::sq_ptr_t head_o,
	sq_ctrl_if.alloc         ctrl
);
	import lsq_pkg::*;

	sq_ptr_t head_q;
	sq_ptr_t cmt_q;
	sq_ptr_t tail_q;
	logic    full;
	logic    disp_fire;
	logic    commit_fire;

	// same index, different lap
	assign full = (head_q[SQ_IDX_W-1:0] == tail_q[SQ_IDX_W-1:0]) &&
		(head_q[SQ_IDX_W] != tail_q[SQ_IDX_W]);

	assign disp_ready_o = ~full;
	assign disp_idx_o   = tail_q[SQ_IDX_W-1:0];
	assign head_o       = head_q;

	assign disp_fire = disp_i & ~full;
	// nothing to commit once commit pointer catches the tail
	assign commit_fire = commit_i && (cmt_q != tail_q);

	assign ctrl.alloc_en   = disp_fire;
	assign ctrl.alloc_idx  = tail_q[SQ_IDX_W-1:0];
	assign ctrl.commit_en  = commit_fire;
	assign ctrl.commit_idx = cmt_q[SQ_IDX_W-1:0];
	assign ctrl.free_en    = drain_done_i;
	assign ctrl.free_idx   = head_q[SQ_IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			cmt_q  <= '0;
			tail_q <= '0;
		end else begin
			if (disp_fire)
				tail_q <= tail_q + 1'b1;
			if (commit_fire)
				cmt_q <= cmt_q + 1'b1;
			if (drain_done_i)
				head_q <= head_q + 1'b1;
		end
	end

endmodule

/* logic/sq_slot.sv */
// Store queue slot
// state bits, address and data of one store, with the load address compare
module sq_slot #(
	parameter lsq_pkg::sq_idx_t SLOT = '0
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             st_wr_i,
	input  lsq_pkg::sq_idx_t st_idx_i,
	input  lsq_pkg::addr_t   st_addr_i,
	input  lsq_pkg::data_t   st_data_i,
	sq_ctrl_if.slot          ctrl,
	sq_view_if.slot          view
);
	import lsq_pkg::*;

	logic  valid_q;
	logic  addr_vld_q;
	logic  committed_q;
	addr_t addr_q;
	data_t data_q;
	logic  wr_hit;

	assign wr_hit = st_wr_i && (st_idx_i == SLOT);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q     <= 1'b0;
			addr_vld_q  <= 1'b0;
			committed_q <= 1'b0;
		end else begin
			if (ctrl.alloc_en && ctrl.alloc_idx == SLOT) begin
				valid_q     <= 1'b1;
				addr_vld_q  <= 1'b0;
				committed_q <= 1'b0;
			end
			if (wr_hit)
				addr_vld_q <= 1'b1;
			if (ctrl.commit_en && ctrl.commit_idx == SLOT)
				committed_q <= 1'b1;
			// drained, slot goes back to the pool
			if (ctrl.free_en && ctrl.free_idx == SLOT) begin
				valid_q     <= 1'b0;
				committed_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hit) begin
			addr_q <= st_addr_i;
			data_q <= st_data_i;
		end
	end

	assign view.valid[SLOT]     = valid_q;
	assign view.addr_vld[SLOT]  = addr_vld_q;
	assign view.committed[SLOT] = committed_q;
	assign view.addr[SLOT]      = addr_q;
	assign view.data[SLOT]      = data_q;
	assign view.match[SLOT]     = valid_q && addr_vld_q && (addr_q == view.search_addr);

endmodule

/* logic/sq_search.sv */
// Store queue search
// finds the stores older than a load, checks their addresses are known
// and forwards the data of the youngest older store that matches
module sq_search (
	input  lsq_pkg::sq_ptr_t head_i,
	input  lsq_pkg::sq_ptr_t ld_pos_i,
	sq_view_if.search        view,
	output logic             older_known_o,
	output logic             fwd_hit_o,
	output lsq_pkg::data_t   fwd_data_o
);
	import lsq_pkg::*;

	sq_idx_t head_idx;
	// number of older stores, 0 up to a full queue
	sq_ptr_t span;

	assign head_idx = head_i[SQ_IDX_W-1:0];
	// pointer difference covers wrap-around and the full case
	assign span = ld_pos_i - head_i;

	// ******************************************************************
	// walk from oldest to youngest, later hits overwrite earlier ones
	// ******************************************************************
	always_comb begin
		sq_idx_t slot_idx;

		older_known_o = 1'b1;
		fwd_hit_o     = 1'b0;
		fwd_data_o    = '0;
		for (int k = 0; k < SQ_ENTRIES; k++) begin
			slot_idx = head_idx + SQ_IDX_W'(k);
			if (k < int'(span) && view.valid[slot_idx]) begin
				if (!view.addr_vld[slot_idx])
					older_known_o = 1'b0;
				if (view.match[slot_idx]) begin
					fwd_hit_o  = 1'b1;
					fwd_data_o = view.data[slot_idx];
				end
			end
		end
	end

endmodule

/* logic/st_drain.sv */
// Store drain
// writes the committed head store to memory over a four-phase req/ack port
module st_drain (
	input  logic             clk,
	input  logic             rst,
	input  lsq_pkg::sq_ptr_t head_i,
	sq_view_if.drain         view,
	input  logic             st_ack_i,
	output logic             st_req_o,
	output lsq_pkg::addr_t   st_addr_o,
	output lsq_pkg::data_t   st_data_o,
	output logic             drain_done_o
);
	import lsq_pkg::*;

	drain_state_e state_q;
	drain_state_e state_d;
	sq_idx_t      head_idx;

	assign head_idx = head_i[SQ_IDX_W-1:0];

	// head does not move while a write is open, so these stay stable
	assign st_addr_o = view.addr[head_idx];
	assign st_data_o = view.data[head_idx];

	assign st_req_o     = (state_q == DR_REQ);
	assign drain_done_o = (state_q == DR_RELEASE) && !st_ack_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			DR_IDLE:
				if (view.committed[head_idx])
					state_d = DR_REQ;
			DR_REQ:
				if (st_ack_i)
					state_d = DR_RELEASE;
			// wait for memory to drop ack
			DR_RELEASE:
				if (!st_ack_i)
					state_d = DR_IDLE;
			default:
				state_d = DR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= DR_IDLE;
		else
			state_q <= state_d;
	end

endmodule

/* logic/ld_unit.sv */
// Load unit
// one blocking load: waits on older store addresses, then forwards
// or reads memory over a four-phase port
module ld_unit (
	input  logic           clk,
	input  logic           rst,
	input  logic           ld_req_i,
	input  lsq_pkg::addr_t ld_addr_i,
	input  logic           older_known_i,
	input  logic           fwd_hit_i,
	input  lsq_pkg::data_t fwd_data_i,
	input  logic           mem_rd_ack_i,
	input  lsq_pkg::data_t mem_rd_data_i,
	output logic           ld_ack_o,
	output lsq_pkg::data_t ld_data_o,
	output logic           mem_rd_req_o,
	output lsq_pkg::addr_t mem_rd_addr_o,
	sq_view_if.load        view
);
	import lsq_pkg::*;

	ld_state_e state_q;
	ld_state_e state_d;
	addr_t     addr_q;
	data_t     data_q;

	assign view.search_addr = addr_q;
	assign mem_rd_addr_o    = addr_q;
	assign mem_rd_req_o     = (state_q == LD_MEM_REQ);
	assign ld_ack_o         = (state_q == LD_ACK);
	assign ld_data_o        = data_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			LD_IDLE:
				if (ld_req_i)
					state_d = LD_WAIT_OLDER;
			LD_WAIT_OLDER:
				if (older_known_i)
					state_d = fwd_hit_i ? LD_ACK : LD_MEM_REQ;
			LD_MEM_REQ:
				if (mem_rd_ack_i)
					state_d = LD_MEM_RELEASE;
			LD_MEM_RELEASE:
				if (!mem_rd_ack_i)
					state_d = LD_ACK;
			// hold result until requester lets go
			LD_ACK:
				if (!ld_req_i)
					state_d = LD_IDLE;
			default:
				state_d = LD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= LD_IDLE;
		else
			state_q <= state_d;
	end

	// payload
	always_ff @(posedge clk) begin
		if (state_q == LD_IDLE && ld_req_i)
			addr_q <= ld_addr_i;
		if (state_q == LD_WAIT_OLDER && older_known_i && fwd_hit_i)
			data_q <= fwd_data_i;
		else if (state_q == LD_MEM_REQ && mem_rd_ack_i)
			data_q <= mem_rd_data_i;
	end

endmodule

/* logic/lsq_top.sv */
// Store queue and load path top level
// allocator, slot array, search, store drain and load unit
module lsq_top (
	input  logic             clk,
	input  logic             rst,
	// dispatch
	input  logic             disp_i,
	output logic             disp_ready_o,
	output lsq_pkg::sq_idx_t disp_idx_o,
	// store execute
	input  logic             st_wr_i,
	input  lsq_pkg::sq_idx_t st_idx_i,
	input  lsq_pkg::addr_t   st_addr_i,
	input  lsq_pkg::data_t   st_data_i,
	// commit
	input  logic             commit_i,
	// store memory port
	output logic             st_req_o,
	output lsq_pkg::addr_t   st_addr_o,
	output lsq_pkg::data_t   st_data_o,
	input  logic             st_ack_i,
	// load port
	input  logic             ld_req_i,
	input  lsq_pkg::addr_t   ld_addr_i,
	input  lsq_pkg::sq_ptr_t ld_pos_i,
	output logic             ld_ack_o,
	output lsq_pkg::data_t   ld_data_o,
	// load memory port
	output logic             mem_rd_req_o,
	output lsq_pkg::addr_t   mem_rd_addr_o,
	input  logic             mem_rd_ack_i,
	input  lsq_pkg::data_t   mem_rd_data_i
);
	import lsq_pkg::*;

	sq_ptr_t head;
	logic    drain_done;
	logic    older_known;
	logic    fwd_hit;
	data_t   fwd_data;

	sq_ctrl_if ctrl ();
	sq_view_if view ();

	sq_alloc alloc0 (
		.clk          (clk),
		.rst          (rst),
		.disp_i       (disp_i),
		.commit_i     (commit_i),
		.drain_done_i (drain_done),
		.disp_ready_o (disp_ready_o),
		.disp_idx_o   (disp_idx_o),
		.head_o       (head),
		.ctrl         (ctrl.alloc)
	);

	// ******************************************************************
	// slot array
	// ******************************************************************
	for (genvar g = 0; g < SQ_ENTRIES; g++) begin : g_slot
		sq_slot #(.SLOT(sq_idx_t'(g))) slot (
			.clk       (clk),
			.rst       (rst),
			.st_wr_i   (st_wr_i),
			.st_idx_i  (st_idx_i),
			.st_addr_i (st_addr_i),
			.st_data_i (st_data_i),
			.ctrl      (ctrl.slot),
			.view      (view.slot)
		);
	end

	sq_search search0 (
		.head_i        (head),
		.ld_pos_i      (ld_pos_i),
		.view          (view.search),
		.older_known_o (older_known),
		.fwd_hit_o     (fwd_hit),
		.fwd_data_o    (fwd_data)
	);

	st_drain drain0 (
		.clk          (clk),
		.rst          (rst),
		.head_i       (head),
		.view         (view.drain),
		.st_ack_i     (st_ack_i),
		.st_req_o     (st_req_o),
		.st_addr_o    (st_addr_o),
		.st_data_o    (st_data_o),
		.drain_done_o (drain_done)
	);

	ld_unit ld0 (
		.clk           (clk),
		.rst           (rst),
		.ld_req_i      (ld_req_i),
		.ld_addr_i     (ld_addr_i),
		.older_known_i (older_known),
		.fwd_hit_i     (fwd_hit),
		.fwd_data_i    (fwd_data),
		.mem_rd_ack_i  (mem_rd_ack_i),
		.mem_rd_data_i (mem_rd_data_i),
		.ld_ack_o      (ld_ack_o),
		.ld_data_o     (ld_data_o),
		.mem_rd_req_o  (mem_rd_req_o),
		.mem_rd_addr_o (mem_rd_addr_o),
		.view          (view.load)
	);

endmodule

/* sim/lsq_assertions.sv */
// Store queue and load path checks
// expected-store scoreboard and handshake properties, bound into lsq_top
module lsq_assertions (
	input logic             clk,
	input logic             rst,
	input logic             disp_i,
	input logic             disp_ready_o,
	input lsq_pkg::sq_idx_t disp_idx_o,
	input logic             st_wr_i,
	input lsq_pkg::sq_idx_t st_idx_i,
	input lsq_pkg::addr_t   st_addr_i,
	input lsq_pkg::data_t   st_data_i,
	input logic             commit_i,
	input logic             st_req_o,
	input lsq_pkg::addr_t   st_addr_o,
	input lsq_pkg::data_t   st_data_o,
	input logic             st_ack_i,
	input logic             ld_req_i,
	input lsq_pkg::addr_t   ld_addr_i,
	input lsq_pkg::sq_ptr_t ld_pos_i,
	input logic             ld_ack_o,
	input lsq_pkg::data_t   ld_data_o,
	input logic             mem_rd_req_o,
	input lsq_pkg::addr_t   mem_rd_addr_o,
	input logic             mem_rd_ack_i,
	input lsq_pkg::data_t   mem_rd_data_i
);
	import lsq_pkg::*;

	int unsigned err_cnt = 0;
	sq_ptr_t     m_head;
	sq_ptr_t     m_cmt;
	sq_ptr_t     m_tail;
	sq_ptr_t     m_count;
	sq_ptr_t     span;
	sq_idx_t     head_idx;
	addr_t       sb_addr [SQ_ENTRIES];
	data_t       sb_data [SQ_ENTRIES];
	logic        sb_avld [SQ_ENTRIES];
	logic        ack_q;
	logic        used_mem;
	data_t       mem_data_q;
	logic        exp_known;
	logic        exp_hit;
	data_t       exp_data;

	assign m_count  = m_tail - m_head;
	assign span     = ld_pos_i - m_head;
	assign head_idx = m_head[SQ_IDX_W-1:0];

	task automatic count_fail(string msg);
		$error("%s", msg);
		err_cnt++;
	endtask

	// ******************************************************************
	// scoreboard, stores in program order
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			m_head   <= '0;
			m_cmt    <= '0;
			m_tail   <= '0;
			ack_q    <= 1'b0;
			used_mem <= 1'b0;
		end else begin
			ack_q <= st_ack_i;
			if (disp_i && m_count != sq_ptr_t'(SQ_ENTRIES)) begin
				m_tail <= m_tail + sq_ptr_t'(1);
				sb_avld[m_tail[SQ_IDX_W-1:0]] <= 1'b0;
			end
			if (st_wr_i) begin
				sb_avld[st_idx_i] <= 1'b1;
				sb_addr[st_idx_i] <= st_addr_i;
				sb_data[st_idx_i] <= st_data_i;
			end
			if (commit_i && m_cmt != m_tail)
				m_cmt <= m_cmt + sq_ptr_t'(1);
			// write finished when memory drops ack
			if (ack_q && !st_ack_i)
				m_head <= m_head + sq_ptr_t'(1);
			// load released, next one starts clean
			if (ld_ack_o && !ld_req_i)
				used_mem <= 1'b0;
			else if (mem_rd_req_o)
				used_mem <= 1'b1;
			if (mem_rd_req_o && mem_rd_ack_i)
				mem_data_q <= mem_rd_data_i;
		end
	end

	// expected outcome of the load in flight
	always_comb begin
		sq_idx_t idx;

		exp_known = 1'b1;
		exp_hit   = 1'b0;
		exp_data  = '0;
		for (int k = 0; k < SQ_ENTRIES; k++) begin
			idx = head_idx + SQ_IDX_W'(k);
			if (k < int'(span)) begin
				if (!sb_avld[idx]) begin
					exp_known = 1'b0;
				end else if (sb_addr[idx] == ld_addr_i) begin
					exp_hit  = 1'b1;
					exp_data = sb_data[idx];
				end
			end
		end
	end

	// ******************************************************************
	// properties
	// ******************************************************************
	a_reset: assert property (@(posedge clk)
		rst |=> (!st_req_o && !mem_rd_req_o && !ld_ack_o && disp_ready_o))
		else count_fail("an output was not in its idle state after reset");
	a_ready: assert property (@(posedge clk) disable iff (rst)
		disp_ready_o == (m_count != sq_ptr_t'(SQ_ENTRIES)))
		else count_fail($sformatf("FAIL %0t disp_ready_o got %b exp %b", $time,
			disp_ready_o, m_count != sq_ptr_t'(SQ_ENTRIES)));
	a_idx: assert property (@(posedge clk) disable iff (rst)
		disp_idx_o == m_tail[SQ_IDX_W-1:0])
		else count_fail($sformatf("FAIL %0t disp_idx_o got %0d exp %0d", $time,
			disp_idx_o, m_tail[SQ_IDX_W-1:0]));
	a_st_commit: assert property (@(posedge clk) disable iff (rst)
		$rose(st_req_o) |-> m_cmt != m_head)
		else count_fail("a store went to memory before it was committed");
	a_st_payload: assert property (@(posedge clk) disable iff (rst)
		$rose(st_req_o) |-> st_addr_o == sb_addr[head_idx] && st_data_o == sb_data[head_idx])
		else count_fail($sformatf("FAIL %0t st_addr_o/st_data_o got %h/%h exp %h/%h",
			$time, st_addr_o, st_data_o, sb_addr[head_idx], sb_data[head_idx]));
	a_st_stable: assert property (@(posedge clk) disable iff (rst)
		st_req_o && $past(st_req_o) |-> $stable(st_addr_o) && $stable(st_data_o))
		else count_fail("store address or data changed while st_req_o was high");
	a_st_hold: assert property (@(posedge clk) disable iff (rst)
		st_req_o && !st_ack_i |=> st_req_o)
		else count_fail("st_req_o fell before st_ack_i was seen");
	a_st_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(st_req_o) |-> !st_ack_i)
		else count_fail("st_req_o rose while st_ack_i was still high");
	a_rd_hold: assert property (@(posedge clk) disable iff (rst)
		mem_rd_req_o && !mem_rd_ack_i |=> mem_rd_req_o)
		else count_fail("mem_rd_req_o fell before mem_rd_ack_i was seen");
	a_rd_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_rd_req_o) |-> !mem_rd_ack_i)
		else count_fail("mem_rd_req_o rose while mem_rd_ack_i was still high");
	a_rd_addr: assert property (@(posedge clk) disable iff (rst)
		mem_rd_req_o |-> mem_rd_addr_o == ld_addr_i)
		else count_fail($sformatf("FAIL %0t mem_rd_addr_o got %h exp %h", $time,
			mem_rd_addr_o, ld_addr_i));
	a_ld_wait: assert property (@(posedge clk) disable iff (rst)
		ld_req_i && !exp_known |-> !ld_ack_o && !mem_rd_req_o)
		else count_fail("a load went ahead of an older store with unknown address");
	a_ld_src: assert property (@(posedge clk) disable iff (rst)
		$rose(ld_ack_o) |-> used_mem != exp_hit)
		else count_fail("a load took its data from the wrong source");
	a_ld_fwd: assert property (@(posedge clk) disable iff (rst)
		$rose(ld_ack_o) && exp_hit |-> ld_data_o == exp_data)
		else count_fail($sformatf("FAIL %0t ld_data_o got %h exp %h", $time,
			ld_data_o, exp_data));
	a_ld_mem: assert property (@(posedge clk) disable iff (rst)
		$rose(ld_ack_o) && !exp_hit |-> ld_data_o == mem_data_q)
		else count_fail($sformatf("FAIL %0t ld_data_o got %h exp %h", $time,
			ld_data_o, mem_data_q));
	a_ld_hold: assert property (@(posedge clk) disable iff (rst)
		ld_ack_o && ld_req_i |=> ld_ack_o)
		else count_fail("ld_ack_o fell while ld_req_i was still high");
	a_ld_release: assert property (@(posedge clk) disable iff (rst)
		ld_ack_o && !ld_req_i |=> !ld_ack_o)
		else count_fail("ld_ack_o stayed high after ld_req_i fell");

endmodule

bind lsq_top lsq_assertions asrt0 (
	.clk           (clk),
	.rst           (rst),
	.disp_i        (disp_i),
	.disp_ready_o  (disp_ready_o),
	.disp_idx_o    (disp_idx_o),
	.st_wr_i       (st_wr_i),
	.st_idx_i      (st_idx_i),
	.st_addr_i     (st_addr_i),
	.st_data_i     (st_data_i),
	.commit_i      (commit_i),
	.st_req_o      (st_req_o),
	.st_addr_o     (st_addr_o),
	.st_data_o     (st_data_o),
	.st_ack_i      (st_ack_i),
	.ld_req_i      (ld_req_i),
	.ld_addr_i     (ld_addr_i),
	.ld_pos_i      (ld_pos_i),
	.ld_ack_o      (ld_ack_o),
	.ld_data_o     (ld_data_o),
	.mem_rd_req_o  (mem_rd_req_o),
	.mem_rd_addr_o (mem_rd_addr_o),
	.mem_rd_ack_i  (mem_rd_ack_i),
	.mem_rd_data_i (mem_rd_data_i)
);

/* sim/tb_lsq.sv */
// Store queue and load path testbench
// clock, reset, memory model for both ports and the store/load stimulus
module tb_lsq;
	import lsq_pkg::*;

	localparam int    TIMEOUT   = 200;
	localparam int    MAX_CYCLE = 5000;
	localparam data_t SEED      = 64'd1;

	logic    clk;
	logic    rst;
	logic    disp_i;
	logic    disp_ready_o;
	sq_idx_t disp_idx_o;
	logic    st_wr_i;
	sq_idx_t st_idx_i;
	addr_t   st_addr_i;
	data_t   st_data_i;
	logic    commit_i;
	logic    st_req_o;
	addr_t   st_addr_o;
	data_t   st_data_o;
	logic    st_ack_i;
	logic    ld_req_i;
	addr_t   ld_addr_i;
	sq_ptr_t ld_pos_i;
	logic    ld_ack_o;
	data_t   ld_data_o;
	logic    mem_rd_req_o;
	addr_t   mem_rd_addr_o;
	logic    mem_rd_ack_i;
	data_t   mem_rd_data_i;
	data_t   rnd;
	int      drained;

	lsq_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic data_t xorshift(data_t x);
		data_t y;

		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	task automatic abort(string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	// ******************************************************************
	// memory model, acks follow req one cycle later
	// ******************************************************************
	initial begin : mem_model
		logic st_req_seen;
		logic rd_req_seen;

		st_ack_i      = 1'b0;
		mem_rd_ack_i  = 1'b0;
		mem_rd_data_i = '0;
		st_req_seen   = 1'b0;
		rd_req_seen   = 1'b0;
		drained       = 0;
		forever begin
			@(negedge clk);
			// ack drops now, the write is over
			if (st_ack_i && !st_req_seen)
				drained++;
			st_ack_i    = st_req_seen;
			st_req_seen = st_req_o;
			if (rd_req_seen)
				mem_rd_data_i = xorshift({32'b0, mem_rd_addr_o} ^ SEED);
			mem_rd_ack_i = rd_req_seen;
			rd_req_seen  = mem_rd_req_o;
		end
	end

	task automatic dispatch(output sq_idx_t idx);
		int n;

		n = 0;
		while (!disp_ready_o) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort("timeout: the store queue never offered a free slot");
		end
		idx    = disp_idx_o;
		disp_i = 1'b1;
		@(negedge clk);
		disp_i = 1'b0;
	endtask

	task automatic write_store(sq_idx_t idx, addr_t addr);
		rnd       = xorshift(rnd);
		st_wr_i   = 1'b1;
		st_idx_i  = idx;
		st_addr_i = addr;
		st_data_i = rnd;
		@(negedge clk);
		st_wr_i = 1'b0;
	endtask

	task automatic commit(int n);
		commit_i = 1'b1;
		repeat (n) @(negedge clk);
		commit_i = 1'b0;
	endtask

	task automatic wait_drained(int n);
		int t;

		t = 0;
		while (drained < n) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort("timeout: committed stores were not written to memory");
		end
		// head moves on the following edge
		@(negedge clk);
	endtask

	task automatic start_load(addr_t addr, sq_ptr_t pos);
		ld_req_i  = 1'b1;
		ld_addr_i = addr;
		ld_pos_i  = pos;
	endtask

	task automatic finish_load();
		int t;

		t = 0;
		while (!ld_ack_o) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort("timeout: the load was never acknowledged");
		end
		// keep the request up for a cycle with ack high
		@(negedge clk);
		ld_req_i = 1'b0;
		t = 0;
		while (ld_ack_o) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort("timeout: ld_ack_o never fell after the load was released");
		end
	endtask

	task automatic load(addr_t addr, sq_ptr_t pos);
		start_load(addr, pos);
		finish_load();
	endtask

	initial begin : watchdog
		int cycles;

		cycles = 0;
		while (dut0.asrt0.err_cnt == 0 && cycles < MAX_CYCLE) begin
			@(negedge clk);
			cycles++;
		end
		if (dut0.asrt0.err_cnt != 0)
			abort("an assertion failed, see the error above");
		else
			abort("the run went past its cycle limit");
	end

	initial begin : stimulus
		sq_idx_t ids [11];

		disp_i    = 1'b0;
		st_wr_i   = 1'b0;
		st_idx_i  = '0;
		st_addr_i = '0;
		st_data_i = '0;
		commit_i  = 1'b0;
		ld_req_i  = 1'b0;
		ld_addr_i = '0;
		ld_pos_i  = '0;
		rnd       = SEED;
		rst       = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// fill with no drain, then knock once on a full queue
		for (int i = 0; i < SQ_ENTRIES; i++)
			dispatch(ids[i]);
		disp_i = 1'b1;
		@(negedge clk);
		disp_i = 1'b0;

		write_store(ids[0], 32'h100);
		write_store(ids[1], 32'h200);
		// slot 2 still has no address, load must hold
		start_load(32'h200, 4'd3);
		repeat (6) @(negedge clk);
		write_store(ids[2], 32'h300);
		finish_load();

		write_store(ids[7], 32'h200);
		write_store(ids[4], 32'h200);
		write_store(ids[3], 32'h400);
		write_store(ids[6], 32'h200);
		write_store(ids[5], 32'h500);
		load(32'h200, 4'd6);
		load(32'h200, 4'b1000);
		// younger match only
		load(32'h500, 4'd5);
		load(32'h6000, 4'b1000);

		// drain three and wrap the tail around
		commit(3);
		wait_drained(3);
		for (int i = 8; i < 11; i++)
			dispatch(ids[i]);
		write_store(ids[8], 32'h700);
		write_store(ids[9], 32'h200);
		write_store(ids[10], 32'h800);
		load(32'h200, 4'b1011);

		commit(8);
		wait_drained(11);
		load(32'h200, 4'b1011);
		repeat (4) @(negedge clk);

		if (dut0.asrt0.err_cnt == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abort("assertion failures were counted");
		end
	end

endmodule

/* lsq.f */
logic/lsq_pkg.sv
logic/lsq_ifs.sv
logic/sq_alloc.sv
logic/sq_slot.sv
logic/sq_search.sv
logic/st_drain.sv
logic/ld_unit.sv
logic/lsq_top.sv
sim/lsq_assertions.sv
sim/tb_lsq.sv

/* Makefile */
# Verilator build and run for the store queue and load path

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f lsq.f --top-module tb_lsq \
		-Mdir obj_dir -o sim_lsq

run: compile
	./obj_dir/sim_lsq +verilator+error+limit+10 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
